//--- logic/axi_byte_bridge.sv
`timescale 1ns/1ps

module axi_byte_bridge
    import opl3_pkg::*;
(
    input  logic          s_axi_aclk,
    input  logic          s_axi_aresetn,
    input  axi_addr_t     s_axi_awaddr,
    input  logic          s_axi_awvalid,
    output logic          s_axi_awready,
    input  axi_data_t     s_axi_wdata,
    input  axi_strb_t     s_axi_wstrb,
    input  logic          s_axi_wvalid,
    output logic          s_axi_wready,
    output axi_resp_t     s_axi_bresp,
    output logic          s_axi_bvalid,
    input  logic          s_axi_bready,
    input  axi_addr_t     s_axi_araddr,
    input  logic          s_axi_arvalid,
    output logic          s_axi_arready,
    output axi_data_t     s_axi_rdata,
    output axi_resp_t     s_axi_rresp,
    output logic          s_axi_rvalid,
    input  logic          s_axi_rready,
    opl3_reg_bus_if.bridge bus
);

    bridge_state_t state;

    // lane being sent on the byte bus, also the offset from the base address
    logic [1:0] byte_cnt;

    // request captured in the acceptance cycle
    axi_addr_t base_addr;
    axi_data_t wdata_q;
    axi_strb_t wstrb_q;

    logic write_req;
    logic read_req;

    // a new request is only looked at while no ready pulse is in flight
    // writes win when both channels ask in the same cycle
    assign write_req = s_axi_awvalid && s_axi_wvalid && !s_axi_awready && !s_axi_arready;
    assign read_req  = s_axi_arvalid && !s_axi_arready && !s_axi_awready &&
                       !(s_axi_awvalid && s_axi_wvalid);

    // ready goes out one cycle after the request is seen and lasts a single cycle
    // the handshake therefore completes in the cycle where ready is high
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_arready <= 1'b0;
        end else begin
            s_axi_awready <= (state == idle) && write_req;
            s_axi_wready  <= (state == idle) && write_req;
            s_axi_arready <= (state == idle) && read_req;
        end
    end

    // sequencing of the byte cycles and of the response channels
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state        <= idle;
            byte_cnt     <= 2'd0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    byte_cnt <= 2'd0;
                    // leave idle in the acceptance cycle itself
                    if (s_axi_awready) begin
                        state <= writing;
                    end else if (s_axi_arready) begin
                        state <= reading;
                    end
                end
                writing: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) begin
                        state        <= respond;
                        s_axi_bvalid <= 1'b1;
                    end
                end
                reading: begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt == 2'd3) begin
                        state        <= respond;
                        s_axi_rvalid <= 1'b1;
                    end
                end
                respond: begin
                    // nothing new is accepted until the host takes the response
                    if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
                        state        <= idle;
                        s_axi_bvalid <= 1'b0;
                        s_axi_rvalid <= 1'b0;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // address, data and strobes are sampled while ready is high
    always_ff @(posedge s_axi_aclk) begin
        if (state == idle && s_axi_awready) begin
            base_addr <= s_axi_awaddr;
            wdata_q   <= s_axi_wdata;
            wstrb_q   <= s_axi_wstrb;
        end else if (state == idle && s_axi_arready) begin
            base_addr <= s_axi_araddr;
        end
    end

    // read bytes enter at the top and move down, so byte k ends up in lane k
    always_ff @(posedge s_axi_aclk) begin
        if (state == reading) begin
            s_axi_rdata <= {bus.data_out, s_axi_rdata[31:8]};
        end
    end

    // the register address wraps within the bank and the bank never changes
    assign bus.bank_select = base_addr[8];
    assign bus.address     = base_addr[7:0] + reg_addr_t'(byte_cnt);
    assign bus.data_in     = wdata_q[8*byte_cnt +: 8];

    // a lane with its strobe low still takes a cycle but writes nothing
    assign bus.wr = (state == writing) && wstrb_q[byte_cnt];
    assign bus.rd = (state == reading);

    assign s_axi_bresp = AXI_RESP_OKAY;
    assign s_axi_rresp = AXI_RESP_OKAY;

    a_rd_wr_exclusive: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(bus.rd && bus.wr)
    );

    // the write response must survive back-pressure
    a_bvalid_hold: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
    );

    // read data stays put as long as the host holds rready low
    a_rvalid_hold: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
    );

endmodule

//--- logic/opl3_pkg.sv
package opl3_pkg;

    // host side address, data, strobe and response widths of the AXI4-Lite port
    // bit 8 of the byte address picks bank 0 or bank 1 of the chip
    typedef logic [8:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [1:0]  axi_resp_t;

    // the chip side register bus is one byte wide with 256 registers per bank
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // bridge sequencing, one word access becomes four byte cycles
    typedef enum logic [1:0] {
        idle,
        writing,
        reading,
        respond
    } bridge_state_t;

    // every access completes without error
    localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

    // bank 0 registers that the timer block and the status path care about
    localparam reg_addr_t STATUS_ADDR     = 8'h00;
    localparam reg_addr_t TIMER1_ADDR     = 8'h02;
    localparam reg_addr_t TIMER2_ADDR     = 8'h03;
    localparam reg_addr_t TIMER_CTRL_ADDR = 8'h04;

    // clock cycles per timer count, scaled down from 80 us and 320 us
    localparam int TIMER1_TICK_CYCLES = 4;
    localparam int TIMER2_TICK_CYCLES = 16;

    // the prescaler is sized for the slower of the two timers
    localparam int TIMER_PRESCALE_W = $clog2(TIMER2_TICK_CYCLES);
    typedef logic [TIMER_PRESCALE_W-1:0] prescale_t;

endpackage

//--- logic/opl3_reg_bus_if.sv
`timescale 1ns/1ps

// byte wide register bus between the AXI bridge and the chip registers
// a write lands on the rising edge, a read answers in the same cycle
interface opl3_reg_bus_if
    import opl3_pkg::*;
();

    logic      rd;
    logic      wr;
    logic      bank_select;
    reg_addr_t address;
    reg_data_t data_in;
    reg_data_t data_out;

    // the bridge is the only master on this bus
    modport bridge (
        output rd, wr, bank_select, address, data_in,
        input  data_out
    );

    modport reg_file (
        input  rd, wr, bank_select, address, data_in,
        output data_out
    );

    // the timers snoop register writes and never drive anything here
    modport monitor (
        input wr, bank_select, address, data_in
    );

endinterface

//--- logic/opl3_reg_file.sv
`timescale 1ns/1ps

module opl3_reg_file
    import opl3_pkg::*;
(
    input  logic             s_axi_aclk,
    input  logic             s_axi_aresetn,
    opl3_reg_bus_if.reg_file bus,
    input  reg_data_t        status
);

    // both banks in one array, bank 1 starts at index 256
    reg_data_t mem [0:511];

    axi_addr_t mem_index;
    logic      status_hit;
    logic      irq_reset_hit;

    assign mem_index = {bus.bank_select, bus.address};

    // bank 0 address 0 is the live status byte from the timers
    assign status_hit = !bus.bank_select && (bus.address == STATUS_ADDR);

    // bit 7 on the timer control register only clears the flags
    // the stored control value keeps what was last written without it
    assign irq_reset_hit = !bus.bank_select && (bus.address == TIMER_CTRL_ADDR) &&
                           bus.data_in[7];

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            for (int i = 0; i < 512; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.wr && !status_hit && !irq_reset_hit) begin
            mem[mem_index] <= bus.data_in;
        end
    end

    // reads answer in the same cycle so the bridge can capture on the next edge
    always_comb begin
        if (!bus.rd) begin
            bus.data_out = '0;
        end else if (status_hit) begin
            bus.data_out = status;
        end else begin
            bus.data_out = mem[mem_index];
        end
    end

    // a read and a write in the same cycle would make data_out ambiguous
    a_no_rd_wr_overlap: assert property (
        @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(bus.rd && bus.wr)
    );

endmodule

//--- logic/opl3_regs_top.sv
`timescale 1ns/1ps

module opl3_regs_top
    import opl3_pkg::*;
(
    input  logic      s_axi_aclk,
    input  logic      s_axi_aresetn,
    input  axi_addr_t s_axi_awaddr,
    input  logic      s_axi_awvalid,
    output logic      s_axi_awready,
    input  axi_data_t s_axi_wdata,
    input  axi_strb_t s_axi_wstrb,
    input  logic      s_axi_wvalid,
    output logic      s_axi_wready,
    output axi_resp_t s_axi_bresp,
    output logic      s_axi_bvalid,
    input  logic      s_axi_bready,
    input  axi_addr_t s_axi_araddr,
    input  logic      s_axi_arvalid,
    output logic      s_axi_arready,
    output axi_data_t s_axi_rdata,
    output axi_resp_t s_axi_rresp,
    output logic      s_axi_rvalid,
    input  logic      s_axi_rready,
    output logic      irq
);

    // byte register bus shared by the bridge, the storage and the timers
    opl3_reg_bus_if reg_bus ();

    // status byte built by the timers and read back through bank 0 address 0
    reg_data_t status;

    axi_byte_bridge u_bridge (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .bus           (reg_bus.bridge)
    );

    opl3_reg_file u_reg_file (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .bus           (reg_bus.reg_file),
        .status        (status)
    );

    // timers see every register write but only act on their own addresses
    opl3_timers u_timers (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .bus           (reg_bus.monitor),
        .status        (status),
        .irq           (irq)
    );

endmodule

//--- logic/opl3_timers.sv
`timescale 1ns/1ps

module opl3_timers
    import opl3_pkg::*;
(
    input  logic            s_axi_aclk,
    input  logic            s_axi_aresetn,
    opl3_reg_bus_if.monitor bus,
    output reg_data_t       status,
    output logic            irq
);

    // index 0 is timer 1 and index 1 is timer 2
    reg_data_t preset [2];
    reg_data_t count [2];
    prescale_t prescale [2];
    prescale_t tick_end [2];

    logic [1:0] run;
    logic [1:0] mask;
    logic [1:0] flag;

    logic       bank0_wr;
    logic       ctrl_wr;
    logic       irq_reset;
    logic [1:0] start_bits;
    logic [1:0] mask_bits;

    assign tick_end[0] = prescale_t'(TIMER1_TICK_CYCLES - 1);
    assign tick_end[1] = prescale_t'(TIMER2_TICK_CYCLES - 1);

    // only bank 0 writes concern the timers
    assign bank0_wr  = bus.wr && !bus.bank_select;
    assign ctrl_wr   = bank0_wr && (bus.address == TIMER_CTRL_ADDR) && !bus.data_in[7];
    assign irq_reset = bank0_wr && (bus.address == TIMER_CTRL_ADDR) && bus.data_in[7];

    // control byte: bit 0 and bit 1 start, bit 6 masks timer 1, bit 5 masks timer 2
    assign start_bits = bus.data_in[1:0];
    assign mask_bits  = {bus.data_in[5], bus.data_in[6]};

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            run  <= '0;
            mask <= '0;
            flag <= '0;
            for (int i = 0; i < 2; i++) begin
                preset[i]   <= '0;
                count[i]    <= '0;
                prescale[i] <= '0;
            end
        end else begin
            if (bank0_wr && (bus.address == TIMER1_ADDR)) begin
                preset[0] <= bus.data_in;
            end
            if (bank0_wr && (bus.address == TIMER2_ADDR)) begin
                preset[1] <= bus.data_in;
            end
            if (ctrl_wr) begin
                run  <= start_bits;
                mask <= mask_bits;
            end
            for (int i = 0; i < 2; i++) begin
                if (ctrl_wr && start_bits[i]) begin
                    // a start always begins a fresh period from the preset
                    count[i]    <= preset[i];
                    prescale[i] <= '0;
                end else if (run[i]) begin
                    if (prescale[i] == tick_end[i]) begin
                        prescale[i] <= '0;
                        if (count[i] == 8'hFF) begin
                            count[i] <= preset[i];
                            if (!mask[i]) begin
                                flag[i] <= 1'b1;
                            end
                        end else begin
                            count[i] <= count[i] + 8'd1;
                        end
                    end else begin
                        prescale[i] <= prescale[i] + 1'b1;
                    end
                end
            end
            // the irq reset wins over an overflow in the same cycle
            if (irq_reset) begin
                flag <= '0;
            end
        end
    end

    assign status = {flag[0] || flag[1], flag[0], flag[1], 5'b0};
    assign irq    = status[7];

    // a flag can only come from a running, unmasked timer
    for (genvar g = 0; g < 2; g++) begin : g_flag_check
        a_flag_source: assert property (
            @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
            $rose(flag[g]) |-> $past(run[g] && !mask[g])
        );
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the run from its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module opl3_regs_tb \
    -f src.f -o opl3_regs_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/opl3_regs_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0

//--- sim/opl3_regs_tb.sv
`timescale 1ns/1ps

module opl3_regs_tb
    import opl3_pkg::*;
();

    // cycles allowed for a ready or valid handshake, and for the timer 1 overflow
    localparam int HANDSHAKE_LIMIT = 50;
    localparam int IRQ_LIMIT       = 2000;

    typedef enum {
        acc_write,
        acc_read,
        acc_wait_irq,
        acc_idle
    } kind_t;

    // for acc_idle the wdata field is the cycle count and rdata bit 0 the expected irq
    typedef struct {
        kind_t     kind;
        axi_addr_t addr;
        axi_data_t wdata;
        axi_strb_t wstrb;
        axi_data_t rdata;
    } access_t;

    logic      s_axi_aclk;
    logic      s_axi_aresetn;
    axi_addr_t s_axi_awaddr;
    logic      s_axi_awvalid;
    logic      s_axi_awready;
    axi_data_t s_axi_wdata;
    axi_strb_t s_axi_wstrb;
    logic      s_axi_wvalid;
    logic      s_axi_wready;
    axi_resp_t s_axi_bresp;
    logic      s_axi_bvalid;
    logic      s_axi_bready;
    axi_addr_t s_axi_araddr;
    logic      s_axi_arvalid;
    logic      s_axi_arready;
    axi_data_t s_axi_rdata;
    axi_resp_t s_axi_rresp;
    logic      s_axi_rvalid;
    logic      s_axi_rready;
    logic      irq;

    access_t     table_q[$];
    logic [31:0] lfsr_state;

    opl3_regs_top uut (.*);

    always #10 s_axi_aclk = ~s_axi_aclk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // taps 32, 22, 2 and 1, the new bit enters at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
        int cycles;
        int hold;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        cycles = 0;
        do begin
            @(negedge s_axi_aclk);
            cycles++;
            if (cycles > HANDSHAKE_LIMIT) begin
                fail_run("write address and data were never accepted");
            end
        end while (!s_axi_awready);
        // both ready signals pulse together, the handshake closes on the next edge
        check_bit("s_axi_wready", s_axi_wready, 1'b1);
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        cycles = 0;
        while (!s_axi_bvalid) begin
            @(negedge s_axi_aclk);
            cycles++;
            if (cycles > HANDSHAKE_LIMIT) begin
                fail_run("write response never arrived");
            end
        end
        check_resp("s_axi_bresp", s_axi_bresp, AXI_RESP_OKAY);
        // back-pressure on the response, bvalid has to wait for us
        draw_bits(3, hold);
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_bit("s_axi_bvalid", s_axi_bvalid, 1'b1);
        end
        s_axi_bready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int cycles;
        int hold;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        cycles = 0;
        do begin
            @(negedge s_axi_aclk);
            cycles++;
            if (cycles > HANDSHAKE_LIMIT) begin
                fail_run("read address was never accepted");
            end
        end while (!s_axi_arready);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        cycles = 0;
        while (!s_axi_rvalid) begin
            @(negedge s_axi_aclk);
            cycles++;
            if (cycles > HANDSHAKE_LIMIT) begin
                fail_run("read data never arrived");
            end
        end
        check_resp("s_axi_rresp", s_axi_rresp, AXI_RESP_OKAY);
        data = s_axi_rdata;
        // the word must not move while rready is held low
        draw_bits(3, hold);
        repeat (hold) begin
            @(negedge s_axi_aclk);
            check_bit("s_axi_rvalid", s_axi_rvalid, 1'b1);
            check_data("s_axi_rdata", s_axi_rdata, data);
        end
        s_axi_rready = 1'b1;
        @(negedge s_axi_aclk);
        s_axi_rready = 1'b0;
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (!irq) begin
            @(negedge s_axi_aclk);
            cycles++;
            if (cycles > IRQ_LIMIT) begin
                fail_run("irq never rose while timer 1 was running");
            end
        end
    endtask

    // irq is checked at the start of the pause and on every cycle of it
    task automatic idle_cycles(input int count, input logic exp_irq);
        check_bit("irq", irq, exp_irq);
        repeat (count) begin
            @(negedge s_axi_aclk);
            check_bit("irq", irq, exp_irq);
        end
    endtask

    task automatic add_access(input kind_t kind, input axi_addr_t addr, input axi_data_t wdata,
                              input axi_strb_t wstrb, input axi_data_t rdata);
        access_t entry;
        entry.kind  = kind;
        entry.addr  = addr;
        entry.wdata = wdata;
        entry.wstrb = wstrb;
        entry.rdata = rdata;
        table_q.push_back(entry);
    endtask

    task automatic build_table();
        // byte k of the word lands at address + k
        add_access(acc_write, 9'h010, 32'h44332211, 4'hF, 32'h0);
        add_access(acc_read,  9'h010, 32'h0,        4'h0, 32'h44332211);
        // bank 1 is separate storage
        add_access(acc_write, 9'h110, 32'hDDCCBBAA, 4'hF, 32'h0);
        add_access(acc_read,  9'h010, 32'h0,        4'h0, 32'h44332211);
        add_access(acc_read,  9'h110, 32'h0,        4'h0, 32'hDDCCBBAA);
        // wraps to 0xFE, 0xFF, 0x00 and 0x01, the status byte ignores its write
        add_access(acc_write, 9'h0FE, 32'hA5C3B4D2, 4'hF, 32'h0);
        add_access(acc_read,  9'h0FE, 32'h0,        4'h0, 32'hA500B4D2);
        // only lanes 0 and 2 take the new bytes
        add_access(acc_write, 9'h020, 32'h88776655, 4'hF, 32'h0);
        add_access(acc_write, 9'h020, 32'h0D0C0B0A, 4'h5, 32'h0);
        add_access(acc_read,  9'h020, 32'h0,        4'h0, 32'h880C660A);
        // timer 1 preset 0xF0, then start it
        add_access(acc_write, 9'h002, 32'h000000F0, 4'h1, 32'h0);
        add_access(acc_write, 9'h004, 32'h00000001, 4'h1, 32'h0);
        add_access(acc_wait_irq, 9'h000, 32'h0, 4'h0, 32'h0);
        // status shows IRQ and the timer 1 flag, bytes 1 to 3 are stored registers
        add_access(acc_read,  9'h000, 32'h0,        4'h0, 32'h00F0A5C0);
        add_access(acc_write, 9'h004, 32'h00000081, 4'h1, 32'h0);
        add_access(acc_idle,  9'h000, 32'h0,        4'h0, 32'h0);
        add_access(acc_read,  9'h000, 32'h0,        4'h0, 32'h00F0A500);
        add_access(acc_read,  9'h004, 32'h0,        4'h0, 32'h00000001);
        // timer 2 runs masked and timer 1 stops
        add_access(acc_write, 9'h004, 32'h00000022, 4'h1, 32'h0);
        // timer 1 may overflow once more before the stop lands, so clear the flags
        add_access(acc_write, 9'h004, 32'h00000080, 4'h1, 32'h0);
        add_access(acc_idle,  9'h000, axi_data_t'(TIMER2_TICK_CYCLES * 256 * 2), 4'h0, 32'h0);
        add_access(acc_read,  9'h000, 32'h0,        4'h0, 32'h00F0A500);
    endtask

    initial begin
        axi_data_t got;
        s_axi_aclk    = 1'b0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        lfsr_state    = 32'h1c0d;
        build_table();
        repeat (3) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        // control outputs come out of reset low
        check_bit("s_axi_awready", s_axi_awready, 1'b0);
        check_bit("s_axi_wready", s_axi_wready, 1'b0);
        check_bit("s_axi_arready", s_axi_arready, 1'b0);
        check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
        check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
        check_bit("irq", irq, 1'b0);
        foreach (table_q[i]) begin
            case (table_q[i].kind)
                acc_write: axi_write(table_q[i].addr, table_q[i].wdata, table_q[i].wstrb);
                acc_read: begin
                    axi_read(table_q[i].addr, got);
                    check_data("s_axi_rdata", got, table_q[i].rdata);
                end
                acc_wait_irq: wait_irq();
                default: idle_cycles(int'(table_q[i].wdata), table_q[i].rdata[0]);
            endcase
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- src.f
logic/opl3_pkg.sv
logic/opl3_reg_bus_if.sv
logic/axi_byte_bridge.sv
logic/opl3_reg_file.sv
logic/opl3_timers.sv
logic/opl3_regs_top.sv
sim/opl3_regs_tb.sv
